//--- sources.f
+incdir+src
src/biq_pkg.sv
src/biq_buses.sv
src/operand_shifter.sv
src/biq_adder.sv
src/sum_collector.sv
src/biq_add_unit.sv
tb/tb_biq_add_unit.sv

//--- Makefile
# Verilator build and run of the serial bi-quinary adder testbench

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_biq_add_unit

obj_dir/Vtb_biq_add_unit: sources.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_biq_add_unit -f sources.f

run: obj_dir/Vtb_biq_add_unit
	./obj_dir/Vtb_biq_add_unit | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_biq_add_unit.sv
`timescale 1ns/1ps
`include "biq_params.svh"

module tb_biq_add_unit;
   import biq_pkg::*;

   localparam longint unsigned WORD_MOD = 64'd10_000_000_000;
   localparam int TIMEOUT_CYCLES = 40 * (`BIQ_LATENCY + 4);
   localparam biq_word_t BLANK_WORD = {`BIQ_DIGITS{BIQ_BLANK}};

   logic      ap;
   logic      rst;
   logic      start;
   logic      carry_in;
   biq_word_t word_a;
   biq_word_t word_b;
   logic      busy;
   biq_word_t sum_word;
   logic      overflow;
   logic      invalid;
   logic      done;

   // Expectations for the word in flight are set together with its start pulse
   string     test_name;
   biq_word_t exp_word;
   logic      exp_overflow;
   logic      exp_invalid;
   int        edges_since_start = TIMEOUT_CYCLES;
   int        cycle_count = 0;
   int        seed;

   biq_add_unit biq_add_unit_i (
      .ap       (ap),
      .rst      (rst),
      .start    (start),
      .carry_in (carry_in),
      .word_a   (word_a),
      .word_b   (word_b),
      .busy     (busy),
      .sum_word (sum_word),
      .overflow (overflow),
      .invalid  (invalid),
      .done     (done)
   );

   always #5 ap = ~ap;

   // ------------------------------------------------------------------------
   // Decimal to bi-quinary and back
   // ------------------------------------------------------------------------
   // One binary line counts the fives and one quinary line the remainder
   function automatic biq_digit_t encode_digit(input int d);
      biq_digit_t code;
      code = BIQ_BLANK;
      code[d >= 5 ? BIQ_B5 : BIQ_B0] = 1'b1;
      code[BIQ_Q0 + (d % 5)] = 1'b1;
      return code;
   endfunction

   function automatic biq_word_t encode_word(input longint unsigned value);
      biq_word_t       w;
      longint unsigned rest;
      rest = value;
      for (int i = 0; i < `BIQ_DIGITS; i++) begin
         w[i] = encode_digit(int'(rest % 64'd10));
         rest = rest / 64'd10;
      end
      return w;
   endfunction

   // A blank digit reads as '-' and any other illegal code as '?'
   function automatic string digit_text(input biq_digit_t code);
      string s;
      s = (code == BIQ_BLANK) ? "-" : "?";
      for (int d = 0; d < 10; d++) begin
         if (code == encode_digit(d)) begin
            s = $sformatf("%0d", d);
         end
      end
      return s;
   endfunction

   // The top digit is printed first as in a written decimal number
   function automatic string word_text(input biq_word_t w);
      string s;
      s = "";
      for (int i = `BIQ_DIGITS - 1; i >= 0; i--) begin
         s = {s, digit_text(w[i])};
      end
      return s;
   endfunction

   // Ten random decimal digits are built from two five-digit halves
   function automatic longint unsigned random_operand();
      int unsigned hi;
      int unsigned lo;
      hi = $random(seed);
      lo = $random(seed);
      return 64'(hi % 100000) * 64'd100000 + 64'(lo % 100000);
   endfunction

   task automatic report_mismatch(input string what, input string expected,
                                  input string actual);
      $display("[FAIL] %s: %s expected %s, actual %s", test_name, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   // ------------------------------------------------------------------------
   // Checks at done
   // ------------------------------------------------------------------------
   sum_check: assert property (@(posedge ap) disable iff (rst) done |-> sum_word == exp_word)
      else report_mismatch("sum_word", word_text(exp_word), word_text($sampled(sum_word)));

   overflow_check: assert property (@(posedge ap) disable iff (rst)
                                    done |-> overflow == exp_overflow)
      else report_mismatch("overflow", $sformatf("%0b", exp_overflow),
                           $sformatf("%0b", $sampled(overflow)));

   invalid_check: assert property (@(posedge ap) disable iff (rst)
                                   done |-> invalid == exp_invalid)
      else report_mismatch("invalid", $sformatf("%0b", exp_invalid),
                           $sformatf("%0b", $sampled(invalid)));

   // A late, long or extra done pulse all show up as a wrong edge count
   latency_check: assert property (@(posedge ap) disable iff (rst)
                                   done |-> edges_since_start == `BIQ_LATENCY)
      else report_mismatch("done edge", $sformatf("%0d", `BIQ_LATENCY),
                           $sformatf("%0d", $sampled(edges_since_start)));

   busy_check: assert property (@(posedge ap) disable iff (rst)
                                edges_since_start < `BIQ_LATENCY |-> busy)
      else report_mismatch("busy", "1", "0");

   idle_check: assert property (@(posedge ap) disable iff (rst) done |-> !busy)
      else report_mismatch("busy at done", "0", "1");

   // Counts edges since the last accepted start and saturates while idle
   always @(posedge ap) begin
      if (!rst && start && !busy) begin
         edges_since_start <= 0;
      end else if (edges_since_start < TIMEOUT_CYCLES) begin
         edges_since_start <= edges_since_start + 1;
      end
   end

   always @(posedge ap) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Timeout");
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   task automatic run_word(input string name, input biq_word_t a, input biq_word_t b,
                           input logic cin, input biq_word_t expw, input logic expo,
                           input logic expi, input bit poke_busy);
      test_name    = name;
      exp_word     = expw;
      exp_overflow = expo;
      exp_invalid  = expi;
      word_a       = a;
      word_b       = b;
      carry_in     = cin;
      start        = 1'b1;
      @(posedge ap);
      #1;
      start = 1'b0;
      if (poke_busy) begin
         // A second start halfway through the word carries other operands
         repeat (4) begin
            @(posedge ap);
            #1;
         end
         word_a   = encode_word(64'd1234567890);
         word_b   = ~b;
         carry_in = ~cin;
         start    = 1'b1;
         @(posedge ap);
         #1;
         start = 1'b0;
      end
      while (!done) begin
         @(posedge ap);
         #1;
      end
      // The checks see done on the next edge, so hold the expectations until then
      @(posedge ap);
      #1;
   endtask

   task automatic run_add(input string name, input longint unsigned a,
                          input longint unsigned b, input logic cin, input bit poke_busy);
      longint unsigned total;
      total = a + b + 64'(cin);
      run_word(name, encode_word(a), encode_word(b), cin, encode_word(total % WORD_MOD),
               total >= WORD_MOD, 1'b0, poke_busy);
   endtask

   // Digit k of one operand is replaced by an illegal code that blanks
   // digits k and up of the sum
   task automatic run_bad(input string name, input longint unsigned a,
                          input longint unsigned b, input logic cin, input int k,
                          input biq_digit_t code, input bit in_b);
      biq_word_t       wa;
      biq_word_t       wb;
      biq_word_t       expw;
      longint unsigned low_mod;
      wa = encode_word(a);
      wb = encode_word(b);
      if (in_b) begin
         wb[k] = code;
      end else begin
         wa[k] = code;
      end
      low_mod = 64'd1;
      repeat (k) low_mod = low_mod * 64'd10;
      expw = encode_word((a % low_mod + b % low_mod + 64'(cin)) % low_mod);
      for (int i = k; i < `BIQ_DIGITS; i++) begin
         expw[i] = BIQ_BLANK;
      end
      run_word(name, wa, wb, cin, expw, 1'b0, 1'b1, 1'b0);
   endtask

   initial begin
      longint unsigned a;
      longint unsigned b;
      ap                = 1'b0;
      rst               = 1'b1;
      start             = 1'b0;
      carry_in          = 1'b0;
      word_a            = BLANK_WORD;
      word_b            = BLANK_WORD;
      test_name         = "reset";
      exp_word          = BLANK_WORD;
      exp_overflow      = 1'b0;
      exp_invalid       = 1'b0;
      seed              = 32'h28d8f00a;
      repeat (8) @(posedge ap);
      #1;
      rst = 1'b0;

      // Outputs straight after reset
      assert (busy == 1'b0) else report_mismatch("busy", "0", "1");
      assert (done == 1'b0) else report_mismatch("done", "0", "1");
      assert (overflow == 1'b0) else report_mismatch("overflow", "0", "1");
      assert (invalid == 1'b0) else report_mismatch("invalid", "0", "1");
      assert (sum_word == BLANK_WORD)
         else report_mismatch("sum_word", word_text(BLANK_WORD), word_text(sum_word));

      // Plain sums where the first one ripples a carry through all ten digits
      run_add("ripple_carry", 64'd9999999999, 64'd1, 1'b0, 1'b0);
      run_add("zero_plus_zero", 64'd0, 64'd0, 1'b0, 1'b0);
      run_add("half_plus_half", 64'd5000000000, 64'd5000000000, 1'b0, 1'b0);
      run_add("all_nines", 64'd9999999999, 64'd9999999999, 1'b0, 1'b0);
      for (int n = 0; n < 12; n++) begin
         a = random_operand();
         b = random_operand();
         run_add($sformatf("random_%0d", n), a, b, 1'b0, 1'b0);
      end

      // Same operands with the carry insert off and on
      run_add("wrap_no_carry", 64'd9999999999, 64'd0, 1'b0, 1'b0);
      run_add("wrap_carry", 64'd9999999999, 64'd0, 1'b1, 1'b0);
      for (int n = 0; n < 2; n++) begin
         a = random_operand();
         b = random_operand();
         run_add($sformatf("carry_pair_%0d_off", n), a, b, 1'b0, 1'b0);
         run_add($sformatf("carry_pair_%0d_on", n), a, b, 1'b1, 1'b0);
      end

      // Illegal operand digits
      run_bad("blank_digit_3", random_operand(), random_operand(), 1'b0, 3, BIQ_BLANK, 1'b0);
      run_bad("two_q_digit_0", random_operand(), random_operand(), 1'b0, 0, 7'b010_0011, 1'b0);
      run_bad("two_b_digit_9", random_operand(), random_operand(), 1'b1, 9, 7'b110_0100, 1'b1);

      // A dropped start is followed by enough idle edges for a stray done to show up
      run_add("start_while_busy", 64'd4321098765, 64'd1234567890, 1'b1, 1'b1);
      repeat (`BIQ_LATENCY + 2) @(posedge ap);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- src/biq_add_unit.sv
`timescale 1ns/1ps

module biq_add_unit (
   input  logic               ap,
   input  logic               rst,
   input  logic               start,
   input  logic               carry_in,
   input  biq_pkg::biq_word_t word_a,
   input  biq_pkg::biq_word_t word_b,
   output logic               busy,
   output biq_pkg::biq_word_t sum_word,
   output logic               overflow,
   output logic               invalid,
   output logic               done
);

   // Operand digits and sum digits, one digit per clock on each
   digit_bus digit_if ();
   sum_bus   sum_if ();

   // The shifter times busy on its own, so done needs no path back to it
   operand_shifter operand_shifter_i (
      .ap       (ap),
      .rst      (rst),
      .start    (start),
      .carry_in (carry_in),
      .word_a   (word_a),
      .word_b   (word_b),
      .busy     (busy),
      .bus      (digit_if.source)
   );

   biq_adder biq_adder_i (
      .ap  (ap),
      .rst (rst),
      .ops (digit_if.sink),
      .res (sum_if.source)
   );

   sum_collector sum_collector_i (
      .ap       (ap),
      .rst      (rst),
      .res      (sum_if.sink),
      .sum_word (sum_word),
      .overflow (overflow),
      .invalid  (invalid),
      .done     (done)
   );

endmodule

//--- src/sum_collector.sv
`timescale 1ns/1ps
`include "biq_params.svh"

module sum_collector (
   input  logic               ap,
   input  logic               rst,
   sum_bus.sink               res,
   output biq_pkg::biq_word_t sum_word,
   output logic               overflow,
   output logic               invalid,
   output logic               done
);
   import biq_pkg::*;

   biq_word_t assembly;
   biq_word_t assembly_nx;
   logic      in_word;
   logic      bad_digit;
   logic      bad_seen;
   logic      bad_seen_nx;
   logic      word_end;

   // ------------------------------------------------------------------------
   // Digit checks
   // ------------------------------------------------------------------------
   // A good sum digit is a legal code with exactly one carry rail set
   assign bad_digit = ~biq_is_legal(res.sum_digit) | ~(res.carry_out ^ res.no_carry_out);

   // The bus has no first marker, so a valid digit outside a word starts one
   // and the error flag restarts with it
   assign bad_seen_nx = in_word ? (bad_seen | bad_digit) : bad_digit;

   // New digits enter at the top and walk down, so after the last one
   // digit 0 has reached element 0
   assign assembly_nx = {res.sum_digit, assembly[`BIQ_DIGITS-1:1]};

   assign word_end = res.sum_valid & res.sum_last;

   always_ff @(posedge ap) begin
      if (res.sum_valid) begin
         assembly <= assembly_nx;
      end
   end

   // ------------------------------------------------------------------------
   // Result registers, held from done until the next word completes
   // ------------------------------------------------------------------------
   always_ff @(posedge ap) begin
      if (rst) begin
         in_word  <= 1'b0;
         bad_seen <= 1'b0;
         done     <= 1'b0;
         overflow <= 1'b0;
         invalid  <= 1'b0;
         sum_word <= {`BIQ_DIGITS{BIQ_BLANK}};
      end else begin
         done <= word_end;
         if (res.sum_valid) begin
            in_word  <= ~res.sum_last;
            bad_seen <= bad_seen_nx;
         end
         if (word_end) begin
            sum_word <= assembly_nx;
            // Carry out of the top digit means the sum passed ten digits
            overflow <= res.carry_out;
            invalid  <= bad_seen_nx;
         end
      end
   end

endmodule

//--- src/biq_adder.sv
`timescale 1ns/1ps

module biq_adder (
   input logic       ap,
   input logic       rst,
   digit_bus.sink    ops,
   sum_bus.source    res
);
   import biq_pkg::*;

   biq_digit_t a;
   biq_digit_t b;
   logic       carry_hold;
   logic       no_carry_hold;
   logic       carry;
   logic       no_carry;
   logic [4:0] q_or;
   logic [4:0] q_and;
   logic [8:0] qs;
   logic [4:0] residue;
   logic [4:0] sum_q;
   logic       quin_high;
   logic       quin_low;
   logic       both_b5;
   logic       both_b0;
   logic       mixed_b;
   logic       sum_b5;
   logic       sum_b0;
   logic       carry_nx;
   logic       no_carry_nx;
   logic       go;
   biq_digit_t sum_nx;

   assign a = ops.entry_a;
   assign b = ops.entry_b;

   // The first digit of a word ignores the held pair and takes the insert
   assign carry    = ops.first_digit ? ops.carry_insert  : carry_hold;
   assign no_carry = ops.first_digit ? ~ops.carry_insert : no_carry_hold;

   // ------------------------------------------------------------------------
   // Quinary partial sums, qs[n] is set when qa + qb equals n
   // ------------------------------------------------------------------------
   // With one-hot inputs an OR pair can only match the two distinct lines
   // of the two operands, so equal lines need the AND form instead
   assign q_or  = a[BIQ_Q4:BIQ_Q0] | b[BIQ_Q4:BIQ_Q0];
   assign q_and = a[BIQ_Q4:BIQ_Q0] & b[BIQ_Q4:BIQ_Q0];

   assign qs[0] = q_and[0];
   assign qs[1] = q_or[1] & q_or[0];
   assign qs[2] = q_and[1] | (q_or[2] & q_or[0]);
   assign qs[3] = (q_or[3] & q_or[0]) | (q_or[2] & q_or[1]);
   assign qs[4] = q_and[2] | (q_or[4] & q_or[0]) | (q_or[3] & q_or[1]);
   assign qs[5] = (q_or[4] & q_or[1]) | (q_or[3] & q_or[2]);
   assign qs[6] = q_and[3] | (q_or[4] & q_or[2]);
   assign qs[7] = q_or[4] & q_or[3];
   assign qs[8] = q_and[4];

   // Residue of the partial sum modulo five, before the carry is added
   assign residue = {qs[4], qs[3] | qs[8], qs[2] | qs[7], qs[1] | qs[6], qs[0] | qs[5]};

   // An incoming carry rotates the residue up by one quinary line
   assign sum_q = ({5{carry}} & {residue[3:0], residue[4]}) | ({5{no_carry}} & residue);

   // Quinary part plus carry reaching five or more spills into the binary half
   assign quin_high = (|qs[8:5]) | (qs[4] & carry);
   assign quin_low  = (|qs[3:0]) | (qs[4] & no_carry);

   // ------------------------------------------------------------------------
   // Binary half, counted in fives: two b5 lines count 2, mixed lines count 1
   // ------------------------------------------------------------------------
   assign both_b5 = a[BIQ_B5] & b[BIQ_B5];
   assign both_b0 = a[BIQ_B0] & b[BIQ_B0];
   assign mixed_b = (a[BIQ_B5] & b[BIQ_B0]) | (a[BIQ_B0] & b[BIQ_B5]);

   // An odd count of fives leaves b5 set, a count of two or more carries
   assign sum_b5      = (quin_high & (both_b0 | both_b5)) | (quin_low & mixed_b);
   assign sum_b0      = (quin_low & (both_b0 | both_b5)) | (quin_high & mixed_b);
   assign carry_nx    = ((quin_high | quin_low) & both_b5) | (quin_high & mixed_b);
   assign no_carry_nx = (quin_low & (both_b0 | mixed_b)) | (quin_high & both_b0);

   // A bad operand or a dead carry pair blanks the digit and drops both rails,
   // and the dead pair then blanks every later digit of the word as well
   assign go     = biq_is_legal(a) & biq_is_legal(b) & (carry | no_carry);
   assign sum_nx = {sum_b5, sum_b0, sum_q} & {7{go}};

   // ------------------------------------------------------------------------
   // Digit registers
   // ------------------------------------------------------------------------
   always_ff @(posedge ap) begin
      if (rst) begin
         carry_hold       <= 1'b0;
         no_carry_hold    <= 1'b0;
         res.sum_digit    <= BIQ_BLANK;
         res.sum_valid    <= 1'b0;
         res.sum_last     <= 1'b0;
         res.carry_out    <= 1'b0;
         res.no_carry_out <= 1'b0;
      end else begin
         if (ops.digit_valid) begin
            carry_hold    <= carry_nx & go;
            no_carry_hold <= no_carry_nx & go;
         end
         res.sum_digit    <= ops.digit_valid ? sum_nx : BIQ_BLANK;
         res.sum_valid    <= ops.digit_valid;
         res.sum_last     <= ops.digit_valid & ops.last_digit;
         res.carry_out    <= ops.digit_valid & carry_nx & go;
         res.no_carry_out <= ops.digit_valid & no_carry_nx & go;
      end
   end

endmodule

//--- src/operand_shifter.sv
`timescale 1ns/1ps
`include "biq_params.svh"

module operand_shifter (
   input  logic               ap,
   input  logic               rst,
   input  logic               start,
   input  logic               carry_in,
   input  biq_pkg::biq_word_t word_a,
   input  biq_pkg::biq_word_t word_b,
   output logic               busy,
   digit_bus.source           bus
);
   import biq_pkg::*;

   localparam int CNT_W = $clog2(`BIQ_LATENCY + 1);

   biq_word_t        shift_a;
   biq_word_t        shift_b;
   logic             carry_held;
   logic [CNT_W-1:0] edge_cnt;
   logic             accept;
   logic             digit_phase;

   // A start is only taken while idle, a start during a word is dropped
   assign accept = start & ~busy;

   // The counter holds n at edge E(n), so digits leave at E1 through E10
   assign digit_phase = busy & (edge_cnt <= CNT_W'(`BIQ_DIGITS));

   // ------------------------------------------------------------------------
   // Word timing
   // ------------------------------------------------------------------------
   // Busy spans the full latency so that it drops on the same edge the
   // collector raises done
   always_ff @(posedge ap) begin
      if (rst) begin
         busy     <= 1'b0;
         edge_cnt <= '0;
      end else if (accept) begin
         busy     <= 1'b1;
         edge_cnt <= CNT_W'(1);
      end else if (busy) begin
         if (edge_cnt == CNT_W'(`BIQ_LATENCY)) begin
            busy     <= 1'b0;
            edge_cnt <= '0;
         end else begin
            edge_cnt <= edge_cnt + CNT_W'(1);
         end
      end
   end

   // Operand shift registers, digit 0 sits at the low end and leaves first
   always_ff @(posedge ap) begin
      if (accept) begin
         shift_a    <= word_a;
         shift_b    <= word_b;
         carry_held <= carry_in;
      end else if (digit_phase) begin
         shift_a <= {BIQ_BLANK, shift_a[`BIQ_DIGITS-1:1]};
         shift_b <= {BIQ_BLANK, shift_b[`BIQ_DIGITS-1:1]};
      end
   end

   // ------------------------------------------------------------------------
   // Registered digit bus, blank whenever no digit is in flight
   // ------------------------------------------------------------------------
   always_ff @(posedge ap) begin
      if (rst) begin
         bus.entry_a      <= BIQ_BLANK;
         bus.entry_b      <= BIQ_BLANK;
         bus.digit_valid  <= 1'b0;
         bus.first_digit  <= 1'b0;
         bus.last_digit   <= 1'b0;
         bus.carry_insert <= 1'b0;
      end else begin
         bus.entry_a      <= digit_phase ? shift_a[0] : BIQ_BLANK;
         bus.entry_b      <= digit_phase ? shift_b[0] : BIQ_BLANK;
         bus.digit_valid  <= digit_phase;
         bus.first_digit  <= digit_phase & (edge_cnt == CNT_W'(1));
         bus.last_digit   <= digit_phase & (edge_cnt == CNT_W'(`BIQ_DIGITS));
         bus.carry_insert <= digit_phase & (edge_cnt == CNT_W'(1)) & carry_held;
      end
   end

endmodule

//--- src/biq_buses.sv
`timescale 1ns/1ps

// Operand digits from the shifter to the adder, one pair per clock
// There is no back-pressure, the sink takes a digit in the cycle it is valid
interface digit_bus;
   import biq_pkg::*;

   biq_digit_t entry_a;
   biq_digit_t entry_b;
   logic       digit_valid;
   logic       first_digit;
   logic       last_digit;
   // Only meaningful together with first_digit
   logic       carry_insert;

   modport source (output entry_a, entry_b, digit_valid, first_digit, last_digit,
                   carry_insert);
   modport sink   (input entry_a, entry_b, digit_valid, first_digit, last_digit,
                   carry_insert);
endinterface

// Sum digits from the adder to the collector, with the carry rails of each digit
interface sum_bus;
   import biq_pkg::*;

   biq_digit_t sum_digit;
   logic       sum_valid;
   logic       sum_last;
   logic       carry_out;
   logic       no_carry_out;

   modport source (output sum_digit, sum_valid, sum_last, carry_out, no_carry_out);
   modport sink   (input sum_digit, sum_valid, sum_last, carry_out, no_carry_out);
endinterface

//--- src/biq_pkg.sv
`include "biq_params.svh"

package biq_pkg;

   // ------------------------------------------------------------------------
   // One digit is seven lines, ordered b5, b0, q4, q3, q2, q1, q0 high to low
   // ------------------------------------------------------------------------
   typedef logic [6:0] biq_digit_t;

   // Element 0 holds the least significant digit
   typedef biq_digit_t [`BIQ_DIGITS-1:0] biq_word_t;

   // Bit positions of the seven lines inside a digit
   localparam int BIQ_B5 = 6;
   localparam int BIQ_B0 = 5;
   localparam int BIQ_Q4 = 4;
   localparam int BIQ_Q3 = 3;
   localparam int BIQ_Q2 = 2;
   localparam int BIQ_Q1 = 1;
   localparam int BIQ_Q0 = 0;

   // A blank digit has no line set, zero is b0 together with q0
   localparam biq_digit_t BIQ_BLANK = 7'b000_0000;
   localparam biq_digit_t BIQ_ZERO  = 7'b010_0001;

   // A legal code has exactly one binary line and exactly one quinary line
   function automatic logic biq_is_legal(input biq_digit_t d);
      return $onehot(d[BIQ_B5:BIQ_B0]) && $onehot(d[BIQ_Q4:BIQ_Q0]);
   endfunction

endpackage

//--- src/biq_params.svh
`ifndef BIQ_PARAMS_SVH
`define BIQ_PARAMS_SVH

// Digits in one word, least significant digit travels first
`define BIQ_DIGITS 10

// Edges from an accepted start to the done pulse
// One edge to load the operands, one per digit, and one for the adder
// register ahead of the collector
`define BIQ_LATENCY (`BIQ_DIGITS + 2)

// Shift registers and counters are sized from these two values

`endif
